// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ad9516_cfg
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "Simulation reported failures"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir
	rm -f $(LOG)

// File: ad9516_cfg_pkg.sv
package ad9516_cfg_pkg;

        ////////////////////////////////////////
        // Table and frame geometry
        ////////////////////////////////////////
        localparam int CFG_WORDS = 76;
        localparam int IDX_W     = 7;
        localparam int ADDR_W    = 13;
        localparam int DATA_W    = 8;
        localparam int INSTR_W   = 3;
        localparam int FRAME_W   = INSTR_W + ADDR_W + DATA_W;

        typedef logic [ADDR_W-1:0]  reg_addr_t;
        typedef logic [DATA_W-1:0]  reg_data_t;
        typedef logic [FRAME_W-1:0] spi_frame_t;
        typedef logic [IDX_W-1:0]   cfg_idx_t;

        // R/W bit low, W1:W0 = 00 selects a one-byte transfer
        typedef enum logic [INSTR_W-1:0] {
                INSTR_WR_1B = 3'b000
        } spi_instr_e;

        typedef enum logic [1:0] {
                SEQ_IDLE,
                SEQ_ISSUE,
                SEQ_DRAIN,
                SEQ_DONE
        } seq_state_e;

endpackage

// File: ad9516_cfg_top.sv
`timescale 1ns/1ps

module ad9516_cfg_top #(
        parameter int SCLK_HALF_DIV = 4,
        parameter int GAP_HALVES    = 2
) (
        input  logic clk_in,
        input  logic rst_n,
        input  logic i_start,
        output logic o_ready,
        output logic o_sclk,
        output logic o_sda,
        output logic o_cs_n
);
        import ad9516_cfg_pkg::*;

        cfg_idx_t seq_idx;
        logic     shf_idle;
        logic     run;
        logic     in_gap;
        logic     half_tick;
        logic     phase;
        logic     frame_end;
        logic     gap_end;

        spi_word_if word_if ();

        ////////////////////////////////////////
        // Table lookup feeds the word directly
        ////////////////////////////////////////
        ad9516_reg_table u_reg_table (
                .i_idx  (seq_idx),
                .o_addr (word_if.addr),
                .o_data (word_if.data)
        );

        cfg_sequencer u_sequencer (
                .clk_in         (clk_in),
                .rst_n          (rst_n),
                .i_start        (i_start),
                .o_ready        (o_ready),
                .o_idx          (seq_idx),
                .i_shifter_idle (shf_idle),
                .word           (word_if.seq)
        );

        spi_edge_timer #(
                .SCLK_HALF_DIV (SCLK_HALF_DIV),
                .GAP_HALVES    (GAP_HALVES)
        ) u_edge_timer (
                .clk_in      (clk_in),
                .rst_n       (rst_n),
                .i_run       (run),
                .i_in_gap    (in_gap),
                .o_half_tick (half_tick),
                .o_phase     (phase),
                .o_frame_end (frame_end),
                .o_gap_end   (gap_end)
        );

        spi_frame_shifter u_frame_shifter (
                .clk_in      (clk_in),
                .rst_n       (rst_n),
                .word        (word_if.shf),
                .o_run       (run),
                .o_in_gap    (in_gap),
                .i_half_tick (half_tick),
                .i_phase     (phase),
                .i_frame_end (frame_end),
                .i_gap_end   (gap_end),
                .o_idle      (shf_idle),
                .o_sclk      (o_sclk),
                .o_sda       (o_sda),
                .o_cs_n      (o_cs_n)
        );

endmodule

// File: ad9516_cfg_vectors.txt
# S <idle cycles before the start pulse>, one line per run
# F <expected 24-bit frame in hex>, instruction + address + data, used for every run
S 3
S 25
F 000018
F 000100
F 000210
F 000343
F 000400
F 00107C
F 001101
F 001200
F 001308
F 00140C
F 001500
F 001605
F 0017B4
F 001807
F 001900
F 001A45
F 001BE0
F 001C02
F 001D0A
F 001E00
F 001F0E
F 00A001
F 00A100
F 00A200
F 00A301
F 00A400
F 00A500
F 00A601
F 00A700
F 00A800
F 00A901
F 00AA00
F 00AB00
F 00F00A
F 00F10A
F 00F20A
F 00F30A
F 00F40A
F 00F508
F 014003
F 014142
F 014242
F 014343
F 019000
F 019180
F 019200
F 019300
F 019480
F 019500
F 019600
F 019780
F 019800
F 019911
F 019A00
F 019B11
F 019C20
F 019D00
F 019E99
F 019F00
F 01A011
F 01A120
F 01A200
F 01A300
F 01E000
F 01E102
F 023000
F 023100
F 023200
F 001806
F 023201
F 001807
F 023201
F 023001
F 023201
F 023000
F 023201

// File: ad9516_reg_table.sv
`timescale 1ns/1ps

module ad9516_reg_table (
        input  ad9516_cfg_pkg::cfg_idx_t  i_idx,
        output ad9516_cfg_pkg::reg_addr_t o_addr,
        output ad9516_cfg_pkg::reg_data_t o_data
);
        import ad9516_cfg_pkg::*;

        always_comb begin
                case (i_idx)
                // Serial port config and PLL
                7'd0  : {o_addr, o_data} = {13'h0000, 8'h18};
                7'd1  : {o_addr, o_data} = {13'h0001, 8'h00};
                7'd2  : {o_addr, o_data} = {13'h0002, 8'h10};
                7'd3  : {o_addr, o_data} = {13'h0003, 8'h43};
                7'd4  : {o_addr, o_data} = {13'h0004, 8'h00};
                7'd5  : {o_addr, o_data} = {13'h0010, 8'h7C};
                7'd6  : {o_addr, o_data} = {13'h0011, 8'h01};
                7'd7  : {o_addr, o_data} = {13'h0012, 8'h00};
                7'd8  : {o_addr, o_data} = {13'h0013, 8'h08};
                7'd9  : {o_addr, o_data} = {13'h0014, 8'h0C};
                7'd10 : {o_addr, o_data} = {13'h0015, 8'h00};
                7'd11 : {o_addr, o_data} = {13'h0016, 8'h05};
                7'd12 : {o_addr, o_data} = {13'h0017, 8'hB4};
                7'd13 : {o_addr, o_data} = {13'h0018, 8'h07};
                7'd14 : {o_addr, o_data} = {13'h0019, 8'h00};
                7'd15 : {o_addr, o_data} = {13'h001A, 8'h45};
                7'd16 : {o_addr, o_data} = {13'h001B, 8'hE0};
                7'd17 : {o_addr, o_data} = {13'h001C, 8'h02};
                7'd18 : {o_addr, o_data} = {13'h001D, 8'h0A};
                7'd19 : {o_addr, o_data} = {13'h001E, 8'h00};
                7'd20 : {o_addr, o_data} = {13'h001F, 8'h0E};
                // Fine delay adjust
                7'd21 : {o_addr, o_data} = {13'h00A0, 8'h01};
                7'd22 : {o_addr, o_data} = {13'h00A1, 8'h00};
                7'd23 : {o_addr, o_data} = {13'h00A2, 8'h00};
                7'd24 : {o_addr, o_data} = {13'h00A3, 8'h01};
                7'd25 : {o_addr, o_data} = {13'h00A4, 8'h00};
                7'd26 : {o_addr, o_data} = {13'h00A5, 8'h00};
                7'd27 : {o_addr, o_data} = {13'h00A6, 8'h01};
                7'd28 : {o_addr, o_data} = {13'h00A7, 8'h00};
                7'd29 : {o_addr, o_data} = {13'h00A8, 8'h00};
                7'd30 : {o_addr, o_data} = {13'h00A9, 8'h01};
                7'd31 : {o_addr, o_data} = {13'h00AA, 8'h00};
                7'd32 : {o_addr, o_data} = {13'h00AB, 8'h00};
                // LVPECL and LVDS/CMOS outputs
                7'd33 : {o_addr, o_data} = {13'h00F0, 8'h0A};
                7'd34 : {o_addr, o_data} = {13'h00F1, 8'h0A};
                7'd35 : {o_addr, o_data} = {13'h00F2, 8'h0A};
                7'd36 : {o_addr, o_data} = {13'h00F3, 8'h0A};
                7'd37 : {o_addr, o_data} = {13'h00F4, 8'h0A};
                7'd38 : {o_addr, o_data} = {13'h00F5, 8'h08};
                7'd39 : {o_addr, o_data} = {13'h0140, 8'h03};
                7'd40 : {o_addr, o_data} = {13'h0141, 8'h42};
                7'd41 : {o_addr, o_data} = {13'h0142, 8'h42};
                7'd42 : {o_addr, o_data} = {13'h0143, 8'h43};
                // Output dividers
                7'd43 : {o_addr, o_data} = {13'h0190, 8'h00};
                7'd44 : {o_addr, o_data} = {13'h0191, 8'h80};
                7'd45 : {o_addr, o_data} = {13'h0192, 8'h00};
                7'd46 : {o_addr, o_data} = {13'h0193, 8'h00};
                7'd47 : {o_addr, o_data} = {13'h0194, 8'h80};
                7'd48 : {o_addr, o_data} = {13'h0195, 8'h00};
                7'd49 : {o_addr, o_data} = {13'h0196, 8'h00};
                7'd50 : {o_addr, o_data} = {13'h0197, 8'h80};
                7'd51 : {o_addr, o_data} = {13'h0198, 8'h00};
                7'd52 : {o_addr, o_data} = {13'h0199, 8'h11};
                7'd53 : {o_addr, o_data} = {13'h019A, 8'h00};
                7'd54 : {o_addr, o_data} = {13'h019B, 8'h11};
                7'd55 : {o_addr, o_data} = {13'h019C, 8'h20};
                7'd56 : {o_addr, o_data} = {13'h019D, 8'h00};
                7'd57 : {o_addr, o_data} = {13'h019E, 8'h99};
                7'd58 : {o_addr, o_data} = {13'h019F, 8'h00};
                7'd59 : {o_addr, o_data} = {13'h01A0, 8'h11};
                7'd60 : {o_addr, o_data} = {13'h01A1, 8'h20};
                7'd61 : {o_addr, o_data} = {13'h01A2, 8'h00};
                7'd62 : {o_addr, o_data} = {13'h01A3, 8'h00};
                // VCO divider, power down and sync
                7'd63 : {o_addr, o_data} = {13'h01E0, 8'h00};
                7'd64 : {o_addr, o_data} = {13'h01E1, 8'h02};
                7'd65 : {o_addr, o_data} = {13'h0230, 8'h00};
                7'd66 : {o_addr, o_data} = {13'h0231, 8'h00};
                7'd67 : {o_addr, o_data} = {13'h0232, 8'h00};
                // VCO calibration: cal bit low then high, each with an update
                7'd68 : {o_addr, o_data} = {13'h0018, 8'h06};
                7'd69 : {o_addr, o_data} = {13'h0232, 8'h01};
                7'd70 : {o_addr, o_data} = {13'h0018, 8'h07};
                7'd71 : {o_addr, o_data} = {13'h0232, 8'h01};
                // Soft sync pulse to align the outputs
                7'd72 : {o_addr, o_data} = {13'h0230, 8'h01};
                7'd73 : {o_addr, o_data} = {13'h0232, 8'h01};
                7'd74 : {o_addr, o_data} = {13'h0230, 8'h00};
                7'd75 : {o_addr, o_data} = {13'h0232, 8'h01};
                default: {o_addr, o_data} = {reg_addr_t'(0), reg_data_t'(0)};
                endcase
        end

endmodule

// File: cfg_sequencer.sv
`timescale 1ns/1ps

module cfg_sequencer (
        input  logic                     clk_in,
        input  logic                     rst_n,
        input  logic                     i_start,
        output logic                     o_ready,
        output ad9516_cfg_pkg::cfg_idx_t o_idx,
        input  logic                     i_shifter_idle,
        spi_word_if.seq                  word
);
        import ad9516_cfg_pkg::*;

        seq_state_e state;
        logic       xfer;
        logic       last_word;

        assign o_ready    = (state == SEQ_IDLE);
        assign word.valid = (state == SEQ_ISSUE);
        assign xfer       = word.valid && word.ready;
        assign last_word  = (o_idx == cfg_idx_t'(CFG_WORDS - 1));

        always_ff @(posedge clk_in) begin
                if (!rst_n) begin
                        state <= SEQ_IDLE;
                        o_idx <= '0;
                end else begin
                        case (state)
                        SEQ_IDLE: begin
                                if (i_start) begin
                                        o_idx <= '0;
                                        state <= SEQ_ISSUE;
                                end
                        end
                        SEQ_ISSUE: begin
                                if (xfer) begin
                                        if (last_word) begin
                                                state <= SEQ_DRAIN;
                                        end else begin
                                                o_idx <= o_idx + 1'b1;
                                        end
                                end
                        end
                        // Last frame and its gap still running
                        SEQ_DRAIN: begin
                                if (i_shifter_idle) begin
                                        state <= SEQ_DONE;
                                end
                        end
                        default: begin
                                state <= SEQ_IDLE;
                        end
                        endcase
                end
        end

        a_idx_range: assert property (@(posedge clk_in) disable iff (!rst_n)
                word.valid |-> (o_idx <= cfg_idx_t'(CFG_WORDS - 1)));

endmodule

// File: sources.f
ad9516_cfg_pkg.sv
spi_word_if.sv
ad9516_reg_table.sv
cfg_sequencer.sv
spi_edge_timer.sv
spi_frame_shifter.sv
ad9516_cfg_top.sv
tb_ad9516_cfg.sv

// File: spi_edge_timer.sv
`timescale 1ns/1ps

module spi_edge_timer #(
        parameter int SCLK_HALF_DIV = 4,
        parameter int GAP_HALVES    = 2
) (
        input  logic clk_in,
        input  logic rst_n,
        input  logic i_run,
        input  logic i_in_gap,
        output logic o_half_tick,
        output logic o_phase,
        output logic o_frame_end,
        output logic o_gap_end
);
        import ad9516_cfg_pkg::*;

        localparam int FRAME_HALVES = 2 * FRAME_W;
        localparam int EDGE_MAX     = (FRAME_HALVES > GAP_HALVES) ? FRAME_HALVES : GAP_HALVES;
        localparam int EDGE_W       = $clog2(EDGE_MAX);
        localparam int PRE_W        = $clog2(SCLK_HALF_DIV + 1);

        logic [PRE_W-1:0]  pre_cnt;
        logic [EDGE_W-1:0] edge_cnt;

        assign o_half_tick = i_run && (pre_cnt == PRE_W'(SCLK_HALF_DIV - 1));
        assign o_frame_end = o_half_tick && !i_in_gap && (edge_cnt == EDGE_W'(FRAME_HALVES - 1));
        assign o_gap_end   = o_half_tick && i_in_gap && (edge_cnt == EDGE_W'(GAP_HALVES - 1));
        // Odd half-periods are the SCLK high half of a bit
        assign o_phase     = edge_cnt[0];

        always_ff @(posedge clk_in) begin
                if (!rst_n) begin
                        pre_cnt  <= '0;
                        edge_cnt <= '0;
                end else if (!i_run) begin
                        pre_cnt  <= '0;
                        edge_cnt <= '0;
                end else if (o_half_tick) begin
                        pre_cnt  <= '0;
                        edge_cnt <= (o_frame_end || o_gap_end) ? '0 : edge_cnt + 1'b1;
                end else begin
                        pre_cnt  <= pre_cnt + 1'b1;
                end
        end

endmodule

// File: spi_frame_shifter.sv
`timescale 1ns/1ps

module spi_frame_shifter (
        input  logic    clk_in,
        input  logic    rst_n,
        spi_word_if.shf word,
        output logic    o_run,
        output logic    o_in_gap,
        input  logic    i_half_tick,
        input  logic    i_phase,
        input  logic    i_frame_end,
        input  logic    i_gap_end,
        output logic    o_idle,
        output logic    o_sclk,
        output logic    o_sda,
        output logic    o_cs_n
);
        import ad9516_cfg_pkg::*;

        spi_frame_t shift_q;
        logic       in_frame;
        logic       in_gap;
        logic       sclk_q;
        logic       xfer;

        assign o_idle     = !in_frame && !in_gap;
        assign word.ready = o_idle;
        assign xfer       = word.valid && word.ready;
        assign o_run      = in_frame || in_gap;
        assign o_in_gap   = in_gap;
        assign o_cs_n     = !in_frame;
        assign o_sclk     = sclk_q;
        assign o_sda      = shift_q[FRAME_W-1];

        always_ff @(posedge clk_in) begin
                if (!rst_n) begin
                        in_frame <= 1'b0;
                        in_gap   <= 1'b0;
                        sclk_q   <= 1'b0;
                        shift_q  <= '0;
                end else begin
                        if (xfer) begin
                                shift_q  <= {INSTR_WR_1B, word.addr, word.data};
                                in_frame <= 1'b1;
                        end else if (in_frame && i_half_tick) begin
                                // Falling edge moves the next bit onto SDIO
                                if (i_phase) begin
                                        sclk_q  <= 1'b0;
                                        shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
                                end else begin
                                        sclk_q  <= 1'b1;
                                end
                        end
                        if (i_frame_end) begin
                                in_frame <= 1'b0;
                                in_gap   <= 1'b1;
                        end
                        if (i_gap_end) begin
                                in_gap <= 1'b0;
                        end
                end
        end

        a_cs_held: assert property (@(posedge clk_in) disable iff (!rst_n)
                (!o_cs_n && !i_frame_end) |=> !o_cs_n);

        a_sclk_idle: assert property (@(posedge clk_in) disable iff (!rst_n)
                o_cs_n |-> !o_sclk);

endmodule

// File: spi_word_if.sv
`timescale 1ns/1ps

interface spi_word_if;
        import ad9516_cfg_pkg::*;

        logic      valid;
        logic      ready;
        reg_addr_t addr;
        reg_data_t data;

        // Sequencer side offers a word, shifter side takes it
        modport seq (
                output valid,
                output addr,
                output data,
                input  ready
        );

        modport shf (
                input  valid,
                input  addr,
                input  data,
                output ready
        );

endinterface

// File: tb_ad9516_cfg.sv
`timescale 1ns/1ps

module tb_ad9516_cfg;
        import ad9516_cfg_pkg::*;

        localparam int SCLK_HALF_DIV = 4;
        localparam int GAP_HALVES    = 2;
        localparam int CYCLE_LIMIT   = 2 * CFG_WORDS *
                (48 * SCLK_HALF_DIV + GAP_HALVES * SCLK_HALF_DIV + 4) * 2;

        logic clk_in;
        logic rst_n;
        logic i_start;
        logic o_ready;
        logic o_sclk;
        logic o_sda;
        logic o_cs_n;

        int         start_idle[$];
        spi_frame_t exp_frames[$];
        spi_frame_t got_frames[$];
        int         err_frame;
        int         err_count;
        int         err_level;
        int         err_other;
        int         cycle_cnt;
        int         run;

        spi_frame_t cap_frame;
        int         cap_edges;
        logic       sclk_prev;
        logic       cs_prev;

        ad9516_cfg_top #(
                .SCLK_HALF_DIV (SCLK_HALF_DIV),
                .GAP_HALVES    (GAP_HALVES)
        ) dut (
                .clk_in  (clk_in),
                .rst_n   (rst_n),
                .i_start (i_start),
                .o_ready (o_ready),
                .o_sclk  (o_sclk),
                .o_sda   (o_sda),
                .o_cs_n  (o_cs_n)
        );

        initial clk_in = 1'b0;
        always #5 clk_in = ~clk_in;

        task automatic check_frame(input string name, input spi_frame_t exp, input spi_frame_t act);
                if (act !== exp) begin
                        err_frame++;
                        $display("FAIL %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic check_count(input string name, input int exp, input int act);
                if (act != exp) begin
                        err_count++;
                        $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
                end
        endtask

        task automatic check_level(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        err_level++;
                        $display("FAIL %s: expected %b, actual %b", name, exp, act);
                end
        endtask

        task automatic close_run;
                $display("Errors: frame %0d, count %0d, level %0d, other %0d",
                         err_frame, err_count, err_level, err_other);
                if (err_frame + err_count + err_level + err_other == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        endtask

        // ASCII codes of S, F, # and newline are 83, 70, 35 and 10
        task automatic load_vectors;
                int         fd;
                int         c;
                int         rc;
                int         n;
                spi_frame_t f;
                fd = $fopen("ad9516_cfg_vectors.txt", "r");
                if (fd == 0) begin
                        err_other++;
                        $display("Could not open the vector file ad9516_cfg_vectors.txt");
                        return;
                end
                c = $fgetc(fd);
                while (c != -1) begin
                        if (c == 83) begin
                                rc = $fscanf(fd, "%d", n);
                                start_idle.push_back(n);
                        end else if (c == 70) begin
                                rc = $fscanf(fd, "%h", f);
                                exp_frames.push_back(f);
                        end else if (c == 35) begin
                                while (c != -1 && c != 10) begin
                                        c = $fgetc(fd);
                                end
                        end
                        c = $fgetc(fd);
                end
                $fclose(fd);
        endtask

        ////////////////////////////////////////
        // One load run with a stray start
        ////////////////////////////////////////
        task automatic run_sequence(input int r);
                int extra_at;
                int waited;
                int n;
                int i;
                repeat (start_idle[r]) @(negedge clk_in);
                got_frames.delete();
                extra_at = 1 + int'($urandom % 10000);
                i_start = 1'b1;
                @(negedge clk_in);
                i_start = 1'b0;
                check_level($sformatf("run %0d busy after start", r), 1'b0, o_ready);
                waited = 0;
                while (!o_ready) begin
                        @(negedge clk_in);
                        waited++;
                        i_start = (waited == extra_at);
                end
                i_start = 1'b0;
                check_count($sformatf("run %0d frame count", r), CFG_WORDS, got_frames.size());
                n = (got_frames.size() < exp_frames.size()) ? got_frames.size() : exp_frames.size();
                for (i = 0; i < n; i++) begin
                        check_frame($sformatf("run %0d frame %0d", r, i),
                                    exp_frames[i], got_frames[i]);
                end
                check_level($sformatf("run %0d cs_n after run", r), 1'b1, o_cs_n);
                check_level($sformatf("run %0d sclk after run", r), 1'b0, o_sclk);
        endtask

        // SPI monitor sampled on the system clock
        always @(posedge clk_in) begin
                if (!rst_n) begin
                        sclk_prev = 1'b0;
                        cs_prev   = 1'b1;
                        cap_edges = 0;
                        cap_frame = '0;
                end else begin
                        if (cs_prev && !o_cs_n) begin
                                cap_edges = 0;
                                cap_frame = '0;
                        end
                        if (!o_cs_n && o_sclk && !sclk_prev) begin
                                cap_frame = {cap_frame[FRAME_W-2:0], o_sda};
                                cap_edges++;
                        end
                        if (o_cs_n && !cs_prev) begin
                                if (cap_edges != FRAME_W) begin
                                        err_other++;
                                        $display("Frame %0d had %0d rising SCLK edges instead of %0d",
                                                 got_frames.size(), cap_edges, FRAME_W);
                                end
                                got_frames.push_back(cap_frame);
                        end
                        if (o_cs_n && o_sclk) begin
                                err_other++;
                                $display("SCLK was high while CS_n was high at %0t", $time);
                        end
                        sclk_prev = o_sclk;
                        cs_prev   = o_cs_n;
                end
        end

        always @(posedge clk_in) begin
                cycle_cnt++;
                if (cycle_cnt == CYCLE_LIMIT) begin
                        err_other++;
                        $display("Timeout after %0d cycles, the loader did not return to ready",
                                 CYCLE_LIMIT);
                        close_run();
                end
        end

        initial begin
                i_start   = 1'b0;
                rst_n     = 1'b0;
                err_frame = 0;
                err_count = 0;
                err_level = 0;
                err_other = 0;
                cycle_cnt = 0;
                void'($urandom(81));
                load_vectors();
                if (exp_frames.size() != CFG_WORDS) begin
                        err_other++;
                        $display("Vector file holds %0d frames instead of %0d",
                                 exp_frames.size(), CFG_WORDS);
                end
                repeat (10) @(negedge clk_in);
                rst_n = 1'b1;
                @(negedge clk_in);
                check_level("reset o_ready", 1'b1, o_ready);
                check_level("reset o_cs_n", 1'b1, o_cs_n);
                check_level("reset o_sclk", 1'b0, o_sclk);
                if (start_idle.size() == 0) begin
                        err_other++;
                        $display("Vector file holds no start commands");
                end
                for (run = 0; run < start_idle.size(); run++) begin
                        run_sequence(run);
                end
                close_run();
        end

endmodule
